// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := data_mem_tb
FILELIST  := data_mem.f
OBJ_DIR   := obj_dir
LOG       := sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== data_mem.f ====
src/mem_pkg.sv
src/mem_bus_if.sv
src/bram.sv
src/bram_rv.sv
src/mmio_uart.sv
src/mem_router.sv
src/data_mem_top.sv
dv/data_mem_assertions.sv
dv/data_mem_tb.sv

// ==== dv/data_mem_assertions.sv ====
`default_nettype none

// Handshake rules of the data-memory ports, bound to data_mem_top.
module data_mem_assertions (
  input logic                          i_clk,
  input logic                          i_rst,
  input logic                          i_req_valid,
  input logic                          i_req_write,
  input logic [mem_pkg::XLEN-1:0]      i_req_addr,
  input logic [mem_pkg::XLEN-1:0]      i_req_wdata,
  input logic [mem_pkg::NUM_BYTES-1:0] i_req_be,
  input logic                          i_req_ready,  // Top-level o_req_ready.
  input logic                          i_rsp_valid,  // Top-level o_rsp_valid.
  input logic [mem_pkg::XLEN-1:0]      i_rsp_rdata,  // Top-level o_rsp_rdata.
  input logic                          i_rsp_ready,
  input logic                          i_tx_valid,   // Top-level o_tx_valid.
  input mem_pkg::router_state_e        i_state       // Router FSM state.
);
  import mem_pkg::*;

  // ==================================================
  // Request and response channels
  // ==================================================
  req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_req_valid && !i_req_ready) |=> (i_req_valid && $stable(i_req_write) &&
      $stable(i_req_addr) && $stable(i_req_wdata) && $stable(i_req_be)))
    else $error("Request fields changed while the request was stalled.");

  rsp_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_rsp_rdata)))
    else $error("Load response changed under back-pressure.");

  // ==================================================
  // Reset and router state
  // ==================================================
  tx_idle_after_reset: assert property (@(posedge i_clk) i_rst |=> !i_tx_valid)
    else $error("Transmit valid was high in the cycle after reset.");

  logic load_open;  // A load was accepted on the port and its response has not left.

  // Tracked from the port handshakes alone.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      load_open <= 1'b0;
    end else if (i_req_valid && i_req_ready && !i_req_write) begin
      load_open <= 1'b1;  // Load taken.
    end else if (i_rsp_valid && i_rsp_ready) begin
      load_open <= 1'b0;  // Response transferred.
    end
  end

  // The router waits exactly while a load is outstanding on the port.
  wait_matches_load: assert property (@(posedge i_clk) disable iff (i_rst)
    ((i_state == RT_WAIT_RSP) == load_open))
    else $error("Router state did not match the outstanding load on the port.");

  // A waiting router must not take a new request.
  no_ready_in_wait: assert property (@(posedge i_clk) disable iff (i_rst)
    !(load_open && i_req_ready))
    else $error("Request ready was high while a load response was pending.");

endmodule

`default_nettype wire

// ==== dv/data_mem_tb.sv ====
`default_nettype none

module data_mem_tb;
  import mem_pkg::*;

  localparam int ADDR_WIDTH = 6;
  localparam int TX_DEPTH   = 4;
  localparam int N_WORDS    = 32;    // Addresses used by the RAM tests.
  localparam int MAX_CYCLES = 4000;  // About ten times the length of all tests.
  localparam int TX_HOLD    = 0;     // Serializer never takes a byte.
  localparam int TX_OPEN    = 1;     // Serializer takes every byte.
  localparam int TX_TOGGLE  = 2;     // Serializer ready at random.

  logic        i_clk;
  logic        i_rst;
  logic        i_req_valid;
  logic        i_req_write;
  logic [31:0] i_req_addr;
  logic [31:0] i_req_wdata;
  logic [3:0]  i_req_be;
  logic        o_req_ready;
  logic        o_rsp_valid;
  logic [31:0] o_rsp_rdata;
  logic        i_rsp_ready;
  logic        o_tx_valid;
  logic [7:0]  o_tx_byte;
  logic        i_tx_ready;
  logic        i_rx_valid;
  logic [7:0]  i_rx_byte;
  logic        o_rx_ready;

  integer      seed = 32'h49ffae47;
  logic [31:0] mem_model [2**ADDR_WIDTH];  // Expected RAM words by index.
  logic [31:0] addr_list [N_WORDS];        // Addresses written in the first test.
  logic [31:0] exp_data_q [$];             // Expected load data in order.
  string       exp_name_q [$];             // Test name of each pending load.
  logic [7:0]  tx_model_q [$];             // Bytes pushed and not yet sent.
  logic [7:0]  rx_held;                    // Byte offered to the receiver.
  int          tx_mode = TX_HOLD;
  int          cycle_count = 0;
  bit          verdict_done = 1'b0;

  data_mem_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .TX_DEPTH   (TX_DEPTH)
  ) u_dut (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_req_valid (i_req_valid), .i_req_write (i_req_write), .i_req_addr (i_req_addr),
    .i_req_wdata (i_req_wdata), .i_req_be (i_req_be), .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid), .o_rsp_rdata (o_rsp_rdata), .i_rsp_ready (i_rsp_ready),
    .o_tx_valid (o_tx_valid), .o_tx_byte (o_tx_byte), .i_tx_ready (i_tx_ready),
    .i_rx_valid (i_rx_valid), .i_rx_byte (i_rx_byte), .o_rx_ready (o_rx_ready)
  );

  bind data_mem_top data_mem_assertions u_assertions (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_req_valid (i_req_valid), .i_req_write (i_req_write), .i_req_addr (i_req_addr),
    .i_req_wdata (i_req_wdata), .i_req_be (i_req_be), .i_req_ready (o_req_ready),
    .i_rsp_valid (o_rsp_valid), .i_rsp_rdata (o_rsp_rdata), .i_rsp_ready (i_rsp_ready),
    .i_tx_valid (o_tx_valid), .i_state (u_router.state)
  );

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  be);
    logic [31:0] result;
    result = old_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (be[lane]) result[lane*8 +: 8] = new_word[lane*8 +: 8];  // Enabled lanes change.
    end
    return result;
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return int'(addr[ADDR_WIDTH+1:2]);  // Bits above the RAM size alias.
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] addr);
    if (addr == MMIO_TX_ADDR) return {8'(TX_DEPTH - tx_model_q.size()), 24'h0};
    else if (addr == MMIO_RX_ADDR) return {8'h00, rx_held, 16'h0000};
    else return mem_model[word_index(addr)];
  endfunction

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
      $display("TEST FAILED");
      verdict_done = 1'b1;
      $fatal(1, "Mismatch in %s.", name);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("Error: %s", reason);
    $display("TEST FAILED");
    verdict_done = 1'b1;
    $fatal(1, "%s", reason);
  endtask

  // ==================================================
  // Bus tasks
  // ==================================================
  task automatic next_cycle();
    @(posedge i_clk);
    #1;  // Inputs change just after the edge.
  endtask

  task automatic drive_request(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be);
    i_req_valid = 1'b1;
    i_req_write = write;
    i_req_addr  = addr;
    i_req_wdata = wdata;
    i_req_be    = be;
  endtask

  task automatic wait_accept();
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge i_clk);
      accepted = o_req_ready;  // Transfer happens on the coming edge.
      next_cycle();
    end
    i_req_valid = 1'b0;
  endtask

  task automatic expect_stall(input string name, input int cycles);
    repeat (cycles) begin
      @(negedge i_clk);
      if (o_req_ready) abort_run({name, ": request was accepted but should have stalled"});
      next_cycle();
    end
  endtask

  task automatic finish_store(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be);
    wait_accept();
    if (addr == MMIO_TX_ADDR) tx_model_q.push_back(wdata[31:24]);  // Lane 3 is sent.
    else if (addr != MMIO_RX_ADDR) mem_model[word_index(addr)] =
      merge_word(mem_model[word_index(addr)], wdata, be);
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be);
    drive_request(1'b1, addr, wdata, be);
    finish_store(addr, wdata, be);
  endtask

  task automatic wait_response();
    while (exp_data_q.size() != 0) next_cycle();  // Compare process drains it.
  endtask

  task automatic load_word(input string name, input logic [31:0] addr);
    exp_name_q.push_back(name);
    exp_data_q.push_back(expected_load(addr));
    drive_request(1'b0, addr, 32'h0, 4'h0);
    wait_accept();
    wait_response();
  endtask

  // ==================================================
  // Clock, serializer, timeout and compare
  // ==================================================
  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    #1;
    case (tx_mode)
      TX_OPEN:   i_tx_ready = 1'b1;
      TX_TOGGLE: i_tx_ready = 1'($random(seed));
      default:   i_tx_ready = 1'b0;
    endcase
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) abort_run("timeout, the tests did not finish in time");
  end

  // Outputs are sampled half a cycle after they change.
  always @(negedge i_clk) begin : compare
    string       name;
    logic [31:0] expected;
    if (!i_rst && o_rsp_valid && i_rsp_ready) begin
      if (exp_data_q.size() == 0) abort_run("load response without an outstanding load");
      name     = exp_name_q.pop_front();
      expected = exp_data_q.pop_front();
      compare_values(name, expected, o_rsp_rdata);
    end
    if (!i_rst && o_tx_valid && i_tx_ready) begin
      if (tx_model_q.size() == 0) abort_run("transmit byte without a matching store");
      compare_values("tx_byte", {24'h0, tx_model_q.pop_front()}, {24'h0, o_tx_byte});
    end
  end

  // An assertion can stop the run before the main sequence reaches its verdict.
  final begin
    if (!verdict_done) $display("TEST FAILED");
  end

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] other;
    int          span;
    i_rst = 1'b1;
    i_req_valid = 1'b0;
    i_req_write = 1'b0;
    i_req_addr = '0;
    i_req_wdata = '0;
    i_req_be = '0;
    i_rsp_ready = 1'b1;
    i_tx_ready = 1'b0;
    i_rx_valid = 1'b0;
    i_rx_byte = '0;
    rx_held = '0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    @(negedge i_clk);
    compare_values("reset_rsp_valid", 32'h0, {31'h0, o_rsp_valid});
    compare_values("reset_tx_valid", 32'h0, {31'h0, o_tx_valid});
    next_cycle();

    for (int i = 0; i < N_WORDS; i++) begin  // Full-word stores.
      addr_list[i] = $random(seed) & 32'hFFFF_FFFC;  // Word aligned, never MMIO.
      store_word(addr_list[i], $random(seed), 4'hF);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      addr = addr_list[i];
      if (i % 2 == 1) addr[31:ADDR_WIDTH+2] = ~addr[31:ADDR_WIDTH+2];  // Alias above RAM.
      load_word("full_word", addr);
    end

    for (int i = 0; i < 16; i++) begin  // Byte-enable merges.
      addr = addr_list[{$random(seed)} % N_WORDS];
      store_word(addr, $random(seed), 4'($random(seed)));
      load_word("byte_enable", addr);
    end

    tx_mode = TX_TOGGLE;  // Four bytes while the serializer drains.
    for (int i = 0; i < 4; i++) store_word(MMIO_TX_ADDR, $random(seed), 4'h8);
    tx_mode = TX_HOLD;
    repeat (2) next_cycle();
    load_word("tx_free_count", MMIO_TX_ADDR);
    tx_mode = TX_OPEN;
    while (tx_model_q.size() != 0) next_cycle();
    load_word("tx_free_empty", MMIO_TX_ADDR);

    tx_mode = TX_HOLD;  // Fill the FIFO, then a fifth store must wait.
    next_cycle();
    for (int i = 0; i < TX_DEPTH; i++) store_word(MMIO_TX_ADDR, $random(seed), 4'h8);
    data = $random(seed);
    drive_request(1'b1, MMIO_TX_ADDR, data, 4'h8);
    expect_stall("tx_full_store", 4);
    tx_mode = TX_OPEN;
    finish_store(MMIO_TX_ADDR, data, 4'h8);
    while (tx_model_q.size() != 0) next_cycle();

    rx_held = 8'($random(seed));  // Receive load waits for a byte.
    exp_name_q.push_back("rx_byte");
    exp_data_q.push_back(expected_load(MMIO_RX_ADDR));
    drive_request(1'b0, MMIO_RX_ADDR, 32'h0, 4'h0);
    expect_stall("rx_empty_load", 4);
    i_rx_valid = 1'b1;
    i_rx_byte  = rx_held;
    @(negedge i_clk);
    if (!o_rx_ready) abort_run("receive holder did not take the offered byte");
    next_cycle();
    i_rx_valid = 1'b0;
    wait_accept();
    wait_response();
    @(negedge i_clk);
    compare_values("rx_ready_after_load", 32'h1, {31'h0, o_rx_ready});
    next_cycle();

    for (int i = 0; i < 6; i++) begin  // Back-pressure on the response.
      addr  = addr_list[{$random(seed)} % N_WORDS];
      other = addr_list[{$random(seed)} % N_WORDS];
      data  = $random(seed);
      span  = 1 + int'({$random(seed)} % 8);
      i_rsp_ready = 1'b0;
      exp_name_q.push_back("backpressure_load");
      exp_data_q.push_back(expected_load(addr));
      drive_request(1'b0, addr, 32'h0, 4'h0);
      wait_accept();
      drive_request(1'b1, other, data, 4'hF);  // Must wait behind the response.
      expect_stall("backpressure_store", span + 2);
      i_rsp_ready = 1'b1;
      finish_store(other, data, 4'hF);
      wait_response();
      load_word("store_after_backpressure", other);
    end

    repeat (4) next_cycle();
    verdict_done = 1'b1;
    if (exp_data_q.size() == 0 && tx_model_q.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("Error: loads or transmit bytes were still outstanding at the end");
      $display("TEST FAILED");
      $fatal(1, "Outstanding traffic at the end of the run.");
    end
  end

endmodule

`default_nettype wire

// ==== src/bram.sv ====
`default_nettype none

// Single-port block RAM with one write enable per byte lane.
module bram #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 10
) (
  input  logic                         i_clk,
  input  logic [DATA_WIDTH/8-1:0][7:0] i_data,               // Write data by lane.
  input  logic [ADDR_WIDTH-1:0]        i_addr,               // Word index.
  input  logic                         i_write,              // Write strobe.
  input  logic [DATA_WIDTH/8-1:0]      i_byte_write_enable,  // Lanes to update.
  output logic [DATA_WIDTH-1:0]        o_data                // Registered read word.
);

  localparam int RAM_SIZE   = 1 << ADDR_WIDTH;  // Words in the array.
  localparam int WORD_BYTES = DATA_WIDTH / 8;   // Lanes per word.

  // ==================================================
  // Storage
  // ==================================================
  logic [WORD_BYTES-1:0][7:0] mem [RAM_SIZE];  // Contents start undefined.

  // The read samples the old word, so a write in the same cycle is
  // seen only by a later read.
  always_ff @(posedge i_clk) begin
    o_data <= mem[i_addr];  // Read before write.
    if (i_write) begin
      for (int lane = 0; lane < WORD_BYTES; lane++) begin
        if (i_byte_write_enable[lane]) begin
          mem[i_addr][lane] <= i_data[lane];  // Only enabled lanes change.
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/bram_rv.sv ====
`default_nettype none

// Valid/ready front end for the block RAM.
module bram_rv #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic      i_clk,
  input  logic      i_rst,
  mem_bus_if.target bus
);
  import mem_pkg::*;

  // ==================================================
  // Request side
  // ==================================================
  logic            rd_pending;  // A load was accepted on the last edge.
  logic            rsp_valid;   // Response register holds a word.
  logic [XLEN-1:0] rsp_data;    // Word returned to the router.
  logic [XLEN-1:0] ram_rdata;   // Registered RAM output.
  logic            rsp_free;    // The response register can take a new word.
  logic            rd_accept;   // A load transfers this cycle.
  logic            wr_en;       // A store transfers this cycle.

  assign rsp_free  = !rd_pending && (!rsp_valid || bus.rsp_ready);  // Held word leaves now.
  assign bus.req_ready = bus.req_write || rsp_free;  // Stores never wait.
  assign rd_accept = bus.req_valid && bus.req_ready && !bus.req_write;
  assign wr_en     = bus.req_valid && bus.req_write;  // Ready is always high for a store.

  // ==================================================
  // Response side
  // ==================================================
  // The RAM word read on the accept edge is taken one edge later.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_pending <= 1'b0;
      rsp_valid  <= 1'b0;
    end else begin
      rd_pending <= rd_accept;  // High for exactly one cycle.
      if (rd_pending) begin
        rsp_valid <= 1'b1;  // Word is ready for the router.
      end else if (bus.rsp_ready) begin
        rsp_valid <= 1'b0;  // Transfer done.
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_pending) begin
      rsp_data <= ram_rdata;  // Held until consumed.
    end
  end

  assign bus.rsp_valid = rsp_valid;
  assign bus.rsp_rdata = rsp_data;

  bram #(
    .DATA_WIDTH (XLEN),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ram (
    .i_clk               (i_clk),
    .i_data              (bus.req_wdata),
    .i_addr              (bus.req_addr),
    .i_write             (wr_en),
    .i_byte_write_enable (bus.req_be),
    .o_data              (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== src/data_mem_top.sv ====
`default_nettype none

// Data-memory subsystem: router, block RAM and UART byte port.
module data_mem_top #(
  parameter int ADDR_WIDTH = 10,  // RAM word-address bits.
  parameter int TX_DEPTH   = 8    // TX FIFO entries, a power of two.
) (
  input  logic                          i_clk,
  input  logic                          i_rst,
  // ==================================================
  // Core request and response
  // ==================================================
  input  logic                          i_req_valid,
  input  logic                          i_req_write,
  input  logic [mem_pkg::XLEN-1:0]      i_req_addr,
  input  logic [mem_pkg::XLEN-1:0]      i_req_wdata,
  input  logic [mem_pkg::NUM_BYTES-1:0] i_req_be,
  output logic                          o_req_ready,
  output logic                          o_rsp_valid,
  output logic [mem_pkg::XLEN-1:0]      o_rsp_rdata,
  input  logic                          i_rsp_ready,
  // ==================================================
  // UART byte streams
  // ==================================================
  output logic                          o_tx_valid,
  output logic [7:0]                    o_tx_byte,
  input  logic                          i_tx_ready,
  input  logic                          i_rx_valid,
  input  logic [7:0]                    i_rx_byte,
  output logic                          o_rx_ready
);

  mem_bus_if #(.ADDR_WIDTH(ADDR_WIDTH)) mem_if ();  // Router to RAM.
  mem_bus_if #(.ADDR_WIDTH(ADDR_WIDTH)) io_if ();   // Router to UART.

  mem_router #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_router (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .i_req_write (i_req_write),
    .i_req_addr  (i_req_addr),
    .i_req_wdata (i_req_wdata),
    .i_req_be    (i_req_be),
    .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_rdata (o_rsp_rdata),
    .i_rsp_ready (i_rsp_ready),
    .mem_if      (mem_if.initiator),
    .io_if       (io_if.initiator)
  );

  bram_rv #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_bram (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .bus   (mem_if.target)
  );

  mmio_uart #(
    .TX_DEPTH (TX_DEPTH)
  ) u_uart (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .bus        (io_if.target),
    .o_tx_valid (o_tx_valid),
    .o_tx_byte  (o_tx_byte),
    .i_tx_ready (i_tx_ready),
    .i_rx_valid (i_rx_valid),
    .i_rx_byte  (i_rx_byte),
    .o_rx_ready (o_rx_ready)
  );

endmodule

`default_nettype wire

// ==== src/mem_bus_if.sv ====
`default_nettype none

// Request and response channels between the router and one target.
interface mem_bus_if #(
  parameter int ADDR_WIDTH = 10
);
  import mem_pkg::*;

  // Request channel, router to target.
  logic                  req_valid;  // Request is present.
  logic                  req_ready;  // Target takes the request this cycle.
  logic                  req_write;  // High for a store, low for a load.
  logic [ADDR_WIDTH-1:0] req_addr;   // Word index for RAM, low byte-address bits for the UART.
  logic [XLEN-1:0]       req_wdata;  // Store data, four byte lanes.
  logic [NUM_BYTES-1:0]  req_be;     // Byte enables of a store.

  // Response channel, target to router.
  logic                  rsp_valid;  // Load data is held.
  logic                  rsp_ready;  // Router passes the response on this cycle.
  logic [XLEN-1:0]       rsp_rdata;  // Load data.

  modport initiator (
    output req_valid, req_write, req_addr, req_wdata, req_be, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport target (
    input  req_valid, req_write, req_addr, req_wdata, req_be, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // ==================================================
  // Word geometry
  // ==================================================
  localparam int XLEN      = 32;        // Width of a data word in bits.
  localparam int NUM_BYTES = XLEN / 8;  // Byte lanes in one word.

  // ==================================================
  // UART port at the top of the address space
  // ==================================================
  localparam logic [XLEN-1:0] MMIO_TX_ADDR = 32'hFFFF_FFFF;  // TX data in, free count out.
  localparam logic [XLEN-1:0] MMIO_RX_ADDR = 32'hFFFF_FFFE;  // Received byte out.

  // Where a decoded request goes.
  typedef enum logic [1:0] {
    REGION_MEM = 2'd0,  // Block RAM behind bram_rv.
    REGION_TX  = 2'd1,  // UART transmit FIFO and its free count.
    REGION_RX  = 2'd2   // UART receive holding register.
  } region_e;

  // Router FSM. A load parks the router until its response has transferred.
  typedef enum logic {
    RT_IDLE     = 1'b0,  // Free to accept a new request.
    RT_WAIT_RSP = 1'b1   // One load outstanding.
  } router_state_e;

endpackage

`default_nettype wire

// ==== src/mem_router.sv ====
`default_nettype none

// Decodes each request to RAM or UART and keeps responses in order.
module mem_router #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_req_valid,
  input  logic                      i_req_write,
  input  logic [mem_pkg::XLEN-1:0]      i_req_addr,   // Byte address.
  input  logic [mem_pkg::XLEN-1:0]      i_req_wdata,
  input  logic [mem_pkg::NUM_BYTES-1:0] i_req_be,
  output logic                      o_req_ready,
  output logic                      o_rsp_valid,
  output logic [mem_pkg::XLEN-1:0]      o_rsp_rdata,
  input  logic                      i_rsp_ready,
  mem_bus_if.initiator              mem_if,       // To bram_rv.
  mem_bus_if.initiator              io_if         // To mmio_uart.
);
  import mem_pkg::*;

  // ==================================================
  // Address decode
  // ==================================================
  region_e       region;      // Target of the request on the port.
  region_e       rsp_region;  // Target of the outstanding load.
  router_state_e state;
  logic          idle;
  logic          to_mem;

  always_comb begin
    if (i_req_addr == MMIO_TX_ADDR)      region = REGION_TX;
    else if (i_req_addr == MMIO_RX_ADDR) region = REGION_RX;
    else                                 region = REGION_MEM;  // Upper bits alias.
  end

  assign idle   = (state == RT_IDLE);
  assign to_mem = (region == REGION_MEM);

  // Fields go to both targets; only valid is steered.
  assign mem_if.req_valid = i_req_valid && idle && to_mem;
  assign mem_if.req_write = i_req_write;
  assign mem_if.req_addr  = i_req_addr[ADDR_WIDTH+1:2];  // Word index.
  assign mem_if.req_wdata = i_req_wdata;
  assign mem_if.req_be    = i_req_be;
  assign io_if.req_valid  = i_req_valid && idle && !to_mem;
  assign io_if.req_write  = i_req_write;
  assign io_if.req_addr   = i_req_addr[ADDR_WIDTH-1:0];  // Bit 0 tells TX from RX.
  assign io_if.req_wdata  = i_req_wdata;
  assign io_if.req_be     = i_req_be;

  assign o_req_ready = idle && (to_mem ? mem_if.req_ready : io_if.req_ready);

  // ==================================================
  // Response steering
  // ==================================================
  assign o_rsp_valid = !idle && ((rsp_region == REGION_MEM) ? mem_if.rsp_valid
                                                           : io_if.rsp_valid);
  assign o_rsp_rdata = (rsp_region == REGION_MEM) ? mem_if.rsp_rdata : io_if.rsp_rdata;
  assign mem_if.rsp_ready = i_rsp_ready && !idle && (rsp_region == REGION_MEM);
  assign io_if.rsp_ready  = i_rsp_ready && !idle && (rsp_region != REGION_MEM);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= RT_IDLE;
      rsp_region <= REGION_MEM;
    end else begin
      case (state)
        RT_IDLE: begin
          if (i_req_valid && o_req_ready && !i_req_write) begin
            state      <= RT_WAIT_RSP;  // Load accepted.
            rsp_region <= region;       // Remember who answers.
          end
        end
        RT_WAIT_RSP: begin
          if (o_rsp_valid && i_rsp_ready) state <= RT_IDLE;  // Response left.
        end
        default: state <= RT_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/mmio_uart.sv ====
`default_nettype none

// Memory-mapped UART byte port: TX FIFO with free count, RX holding register.
module mmio_uart #(
  parameter int TX_DEPTH = 8
) (
  input  logic       i_clk,
  input  logic       i_rst,
  mem_bus_if.target  bus,
  output logic       o_tx_valid,  // Head byte of the FIFO is offered.
  output logic [7:0] o_tx_byte,   // Head byte.
  input  logic       i_tx_ready,  // Serializer takes the head byte.
  input  logic       i_rx_valid,  // A received byte is offered.
  input  logic [7:0] i_rx_byte,   // Received byte.
  output logic       o_rx_ready   // The holding register is empty.
);
  import mem_pkg::*;

  localparam int PTR_W = $clog2(TX_DEPTH);  // Pointers wrap on their own.
  localparam int CNT_W = PTR_W + 1;         // Counter reaches TX_DEPTH.

  // ==================================================
  // Transmit FIFO
  // ==================================================
  logic [7:0]       tx_buf [TX_DEPTH];  // Circular byte store.
  logic [PTR_W-1:0] tx_wr_ptr;          // Next slot to fill.
  logic [PTR_W-1:0] tx_rd_ptr;          // Head slot.
  logic [CNT_W-1:0] tx_count;           // Occupied entries.
  logic [CNT_W-1:0] tx_free;            // Free entries reported to software.
  logic             tx_full;
  logic             tx_push;
  logic             tx_pop;
  logic             is_tx;              // Address bit 0 picks TX, else RX.

  assign is_tx   = bus.req_addr[0];
  assign tx_full = (tx_count == CNT_W'(TX_DEPTH));
  assign tx_free = CNT_W'(TX_DEPTH) - tx_count;
  assign tx_push = bus.req_valid && bus.req_ready && bus.req_write && is_tx;
  assign tx_pop  = o_tx_valid && i_tx_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      tx_wr_ptr <= '0;
      tx_rd_ptr <= '0;
      tx_count  <= '0;
    end else begin
      if (tx_push) tx_wr_ptr <= tx_wr_ptr + 1'b1;
      if (tx_pop)  tx_rd_ptr <= tx_rd_ptr + 1'b1;
      tx_count <= tx_count + CNT_W'(tx_push) - CNT_W'(tx_pop);  // Both may happen.
    end
  end

  always_ff @(posedge i_clk) begin
    if (tx_push) begin
      tx_buf[tx_wr_ptr] <= bus.req_wdata[31:24];  // Byte from lane 3.
    end
  end

  assign o_tx_valid = (tx_count != '0);
  assign o_tx_byte  = tx_buf[tx_rd_ptr];

  // ==================================================
  // Receive holder and load responses
  // ==================================================
  logic                       rx_full;     // A byte waits for a load.
  logic [7:0]                 rx_data;
  logic                       rd_pending;  // Load accepted on the last edge.
  logic                       rsp_valid;
  logic [XLEN-1:0]            rsp_data;
  logic [NUM_BYTES-1:0][7:0]  load_lanes;  // Response word by lane.
  logic                       rsp_free;
  logic                       rd_accept;

  assign o_rx_ready = !rx_full;
  assign rsp_free   = !rd_pending && (!rsp_valid || bus.rsp_ready);
  // Stores to the RX address are dropped; RX loads wait for a byte.
  assign bus.req_ready = bus.req_write ? (!is_tx || !tx_full)
                                       : (rsp_free && (is_tx || rx_full));
  assign rd_accept  = bus.req_valid && bus.req_ready && !bus.req_write;

  always_comb begin
    load_lanes = '0;
    if (is_tx) load_lanes[3] = 8'(tx_free);  // Free count in lane 3.
    else       load_lanes[2] = rx_data;      // Received byte in lane 2.
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rx_full    <= 1'b0;
      rd_pending <= 1'b0;
      rsp_valid  <= 1'b0;
    end else begin
      if (i_rx_valid && o_rx_ready) rx_full <= 1'b1;  // Never overlaps a consume.
      else if (rd_accept && !is_tx)  rx_full <= 1'b0;  // Load takes the byte.
      rd_pending <= rd_accept;
      if (rd_pending)         rsp_valid <= 1'b1;
      else if (bus.rsp_ready) rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rx_valid && o_rx_ready) rx_data  <= i_rx_byte;
    if (rd_accept)                rsp_data <= load_lanes;  // Sampled on accept.
  end

  assign bus.rsp_valid = rsp_valid;
  assign bus.rsp_rdata = rsp_data;

endmodule

`default_nettype wire
